//--- sim.f
hw/xosvm_pkg.sv
hw/vm_config_regs.sv
hw/region_mmu.sv
hw/mem_request_gate.sv
hw/xosvm_unit.sv
bench/xosvm_unit_properties.sv
bench/xosvm_unit_tb.sv

//--- Bender.yml
package:
  name: xosvm_unit

dependencies: {}

sources:
  # Design
  - files:
      - hw/xosvm_pkg.sv
      - hw/vm_config_regs.sv
      - hw/region_mmu.sv
      - hw/mem_request_gate.sv
      - hw/xosvm_unit.sv

  # Testbench
  - target: test
    files:
      - bench/xosvm_unit_properties.sv
      - bench/xosvm_unit_tb.sv

//--- bench/xosvm_unit_tb.sv
module xosvm_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_ROWS     = 10;
    // Worst case per row, plus the reset
    localparam int WATCHDOG_NS  = NUM_ROWS * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    // One table row, region setup first, then the request
    typedef struct packed {
        logic                   ctl;
        xosvm_pkg::addr_t       iofs;
        xosvm_pkg::addr_t       isize;
        xosvm_pkg::addr_t       imask;
        xosvm_pkg::addr_t       dofs;
        xosvm_pkg::addr_t       dsize;
        xosvm_pkg::addr_t       dmask;
        xosvm_pkg::priv_level_e priv;
        xosvm_pkg::addr_t       iaddr;
        xosvm_pkg::addr_t       daddr;
        logic                   rd;
        xosvm_pkg::strobe_t     wstrb;
        logic                   killed;
    } row_t;

    logic                   clk;
    logic                   reset_i;
    logic                   cfg_write_i;
    xosvm_pkg::csr_addr_t   cfg_addr_i;
    xosvm_pkg::addr_t       cfg_data_i;
    xosvm_pkg::priv_level_e privilege_i;
    xosvm_pkg::addr_t       instruction_address_i;
    xosvm_pkg::addr_t       mem_address_i;
    logic                   mem_read_enable_i;
    xosvm_pkg::strobe_t     mem_write_enable_i;
    logic                   killed_i;
    xosvm_pkg::addr_t       instruction_address_o;
    logic                   inst_fault_o;
    xosvm_pkg::addr_t       mem_address_o;
    logic                   data_fault_o;
    logic                   mem_operation_enable_o;
    xosvm_pkg::strobe_t     mem_write_enable_o;

    row_t rows [NUM_ROWS];

    xosvm_unit i_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    // Mask, bound, relocate modulo 2^32
    function automatic xosvm_pkg::xlate_t expect_xlate(
        input logic enable,
        input xosvm_pkg::addr_t address,
        input xosvm_pkg::addr_t offset,
        input xosvm_pkg::addr_t size,
        input xosvm_pkg::addr_t mask
    );
        xosvm_pkg::xlate_t x;
        xosvm_pkg::addr_t  masked;
        logic [32:0]       sum;
        masked = address & mask;
        sum    = {1'b0, masked} + {1'b0, offset};
        if (enable) begin
            x.address = sum[31:0];
            x.fault   = (masked >= size);
        end else begin
            x.address = address;
            x.fault   = 1'b0;
        end
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] time %0d ns, %s: actual %h, expected %h",
                     $time, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Config from one row, request from another
    task automatic check_outputs(input row_t cfg, input row_t req);
        logic              en;
        logic              exp_op;
        xosvm_pkg::xlate_t exp_i;
        xosvm_pkg::xlate_t exp_d;
        en     = cfg.ctl && (req.priv != xosvm_pkg::PRIV_MACHINE);
        exp_i  = expect_xlate(en, req.iaddr, cfg.iofs, cfg.isize, cfg.imask);
        exp_d  = expect_xlate(en, req.daddr, cfg.dofs, cfg.dsize, cfg.dmask);
        exp_op = !req.killed && (req.wstrb != 4'h0 || req.rd) && !exp_d.fault;
        check_value("instruction_address_o", instruction_address_o, exp_i.address);
        check_value("inst_fault_o", inst_fault_o, exp_i.fault);
        check_value("mem_address_o", mem_address_o, exp_d.address);
        check_value("data_fault_o", data_fault_o, exp_d.fault);
        check_value("mem_operation_enable_o", mem_operation_enable_o, exp_op);
        check_value("mem_write_enable_o", mem_write_enable_o, req.wstrb);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic xosvm_pkg::priv_level_e random_priv();
        case ($urandom % 3)
            0: return xosvm_pkg::PRIV_USER;
            1: return xosvm_pkg::PRIV_SUPERVISOR;
            default: return xosvm_pkg::PRIV_MACHINE;
        endcase
    endfunction

    // Seven writes, upper control bits carry junk
    task automatic write_config(input row_t r);
        xosvm_pkg::csr_addr_t addr [7];
        xosvm_pkg::addr_t     data [7];
        xosvm_pkg::addr_t     junk;
        int                   k;
        junk = $urandom;
        addr = '{xosvm_pkg::MVMCTL_ADDR, xosvm_pkg::MVMDO_ADDR, xosvm_pkg::MVMDS_ADDR,
                 xosvm_pkg::MVMDM_ADDR, xosvm_pkg::MVMIO_ADDR, xosvm_pkg::MVMIS_ADDR,
                 xosvm_pkg::MVMIM_ADDR};
        data = '{{junk[31:1], r.ctl}, r.dofs, r.dsize, r.dmask, r.iofs, r.isize, r.imask};
        for (k = 0; k < 7; k++) begin
            @(posedge clk);
            cfg_write_i <= 1'b1;
            cfg_addr_i  <= addr[k];
            cfg_data_i  <= data[k];
        end
    endtask

    task automatic drive_request(input row_t r);
        privilege_i           <= r.priv;
        instruction_address_i <= r.iaddr;
        mem_address_i         <= r.daddr;
        mem_read_enable_i     <= r.rd;
        mem_write_enable_i    <= r.wstrb;
        killed_i              <= r.killed;
    endtask

    task automatic clear_request();
        mem_read_enable_i  <= 1'b0;
        mem_write_enable_i <= 4'h0;
        killed_i           <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        // Control bit clear, passthrough
        rows[0] = '{ctl: 1'b0, iofs: $urandom, isize: $urandom, imask: $urandom,
                    dofs: $urandom, dsize: $urandom, dmask: $urandom,
                    priv: xosvm_pkg::PRIV_USER, iaddr: $urandom, daddr: $urandom,
                    rd: 1'b1, wstrb: 4'h0, killed: 1'b0};
        // Machine mode ignores the control bit
        rows[1] = '{ctl: 1'b1, iofs: $urandom, isize: 32'h0, imask: $urandom,
                    dofs: $urandom, dsize: 32'h0, dmask: $urandom,
                    priv: xosvm_pkg::PRIV_MACHINE, iaddr: $urandom, daddr: $urandom,
                    rd: 1'b0, wstrb: 4'hF, killed: 1'b0};
        // Distinct offsets per channel, in bounds
        rows[2] = '{ctl: 1'b1, iofs: 32'h8000_0000, isize: 32'h0001_0000,
                    imask: 32'h0000_FFFF, dofs: 32'h4000_0000, dsize: 32'h0000_1000,
                    dmask: 32'h0000_0FFF, priv: xosvm_pkg::PRIV_USER,
                    iaddr: $urandom, daddr: $urandom, rd: 1'b1, wstrb: 4'h0, killed: 1'b0};
        // Fetch fault, store still issued
        rows[3] = '{ctl: 1'b1, iofs: 32'h0000_1000, isize: 32'h0000_0100,
                    imask: 32'h0000_FFFF, dofs: 32'h0000_2000, dsize: 32'h0001_0000,
                    dmask: 32'h0000_0FFF, priv: xosvm_pkg::PRIV_SUPERVISOR,
                    iaddr: 32'h0000_0200, daddr: $urandom, rd: 1'b0, wstrb: 4'h3,
                    killed: 1'b0};
        // Data address right at the size
        rows[4] = '{ctl: 1'b1, iofs: $urandom, isize: 32'hFFFF_FFFF, imask: 32'h0000_00FF,
                    dofs: $urandom, dsize: 32'h0000_0040, dmask: 32'h0000_00FF,
                    priv: xosvm_pkg::PRIV_USER, iaddr: $urandom, daddr: 32'h1234_5640,
                    rd: 1'b1, wstrb: 4'h0, killed: 1'b0};
        // Just below the size, but killed
        rows[5] = '{ctl: 1'b1, iofs: $urandom, isize: 32'hFFFF_FFFF, imask: 32'h0000_00FF,
                    dofs: $urandom, dsize: 32'h0000_0040, dmask: 32'h0000_00FF,
                    priv: xosvm_pkg::PRIV_USER, iaddr: $urandom, daddr: 32'h1234_563F,
                    rd: 1'b0, wstrb: 4'hF, killed: 1'b1};
        // No load, no store
        rows[6] = '{ctl: 1'b1, iofs: $urandom, isize: 32'hFFFF_FFFF, imask: $urandom,
                    dofs: $urandom, dsize: 32'hFFFF_FFFF, dmask: 32'h0000_FFFF,
                    priv: xosvm_pkg::PRIV_SUPERVISOR, iaddr: $urandom, daddr: $urandom,
                    rd: 1'b0, wstrb: 4'h0, killed: 1'b0};
        // Offset wraps past 2^32
        rows[7] = '{ctl: 1'b1, iofs: 32'hFFFF_F000, isize: 32'hFFFF_FFFF,
                    imask: 32'hFFFF_FFFF, dofs: 32'hFFFF_F000, dsize: 32'hFFFF_FFFF,
                    dmask: 32'hFFFF_FFFF, priv: xosvm_pkg::PRIV_USER,
                    iaddr: $urandom, daddr: $urandom, rd: 1'b1, wstrb: 4'($urandom),
                    killed: 1'b0};
        // Fully random
        rows[8] = '{ctl: 1'($urandom), iofs: $urandom, isize: $urandom, imask: $urandom,
                    dofs: $urandom, dsize: $urandom, dmask: $urandom, priv: random_priv(),
                    iaddr: $urandom, daddr: $urandom, rd: 1'($urandom),
                    wstrb: 4'($urandom), killed: 1'($urandom)};
        // About half the addresses fault, kept for back-to-back
        rows[9] = '{ctl: 1'b1, iofs: 32'h0010_0000, isize: 32'h0000_8000,
                    imask: 32'h0000_FFFF, dofs: 32'h0020_0000, dsize: 32'h0000_8000,
                    dmask: 32'h0000_FFFF, priv: xosvm_pkg::PRIV_USER,
                    iaddr: $urandom, daddr: $urandom, rd: 1'($urandom),
                    wstrb: 4'($urandom), killed: 1'b0};
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        void'($urandom(32'h54ec));
        clk                   = 1'b0;
        reset_i               = 1'b1;
        // Live write and request held through reset
        cfg_write_i           = 1'b1;
        cfg_addr_i            = xosvm_pkg::MVMCTL_ADDR;
        cfg_data_i            = 32'h0000_0001;
        privilege_i           = xosvm_pkg::PRIV_USER;
        instruction_address_i = 32'h1357_9BDF;
        mem_address_i         = 32'h2468_ACE0;
        mem_read_enable_i     = 1'b1;
        mem_write_enable_i    = 4'hF;
        killed_i              = 1'b0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        reset_i     <= 1'b0;
        cfg_write_i <= 1'b0;
        clear_request();
        @(negedge clk);
        check_value("inst_fault_o", inst_fault_o, 0);
        check_value("data_fault_o", data_fault_o, 0);
        check_value("mem_operation_enable_o", mem_operation_enable_o, 0);
        check_value("mem_write_enable_o", mem_write_enable_o, 0);
        check_value("instruction_address_o", instruction_address_o, 0);
        check_value("mem_address_o", mem_address_o, 0);

        // Full config, idle, one request, check
        for (i = 0; i < NUM_ROWS; i++) begin
            write_config(rows[i]);
            @(posedge clk);
            cfg_write_i <= 1'b0;
            @(posedge clk);
            drive_request(rows[i]);
            @(posedge clk);
            clear_request();
            @(negedge clk);
            check_outputs(rows[i], rows[i]);
        end

        // Back-to-back under the last config, result trails by one cycle
        for (i = 0; i <= NUM_ROWS; i++) begin
            @(posedge clk);
            if (i < NUM_ROWS) begin
                drive_request(rows[i]);
            end else begin
                clear_request();
            end
            @(negedge clk);
            if (i > 0) begin
                check_outputs(rows[NUM_ROWS-1], rows[i-1]);
            end
        end

        $display("All checks passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

//--- bench/xosvm_unit_properties.sv
module xosvm_unit_properties (
    input logic               clk,
    input logic               reset_i,
    input logic               killed_i,
    input logic               inst_fault_o,
    input logic               data_fault_o,
    input logic               mem_operation_enable_o,
    input xosvm_pkg::strobe_t mem_write_enable_o
);

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // Memory issue
    ////////////////////////////////////////////////////////////

    // Faulting data access never reaches memory
    a_data_fault_blocks_op: assert property (
        @(posedge clk) disable iff (reset_i)
        data_fault_o |-> !mem_operation_enable_o
    ) else $error("Memory operation issued on a data fault");

    // Issued op came from a live request one cycle back
    a_op_not_killed: assert property (
        @(posedge clk) disable iff (reset_i)
        mem_operation_enable_o |-> !$past(killed_i)
    ) else $error("Memory operation issued for a killed request");

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    // First cycle out of reset, everything quiet
    a_quiet_after_reset: assert property (
        @(posedge clk)
        $fell(reset_i) |-> (!inst_fault_o && !data_fault_o &&
                            !mem_operation_enable_o && (mem_write_enable_o == '0))
    ) else $error("Control output active right after reset");

endmodule

bind xosvm_unit xosvm_unit_properties i_properties (
    .clk                    (clk),
    .reset_i                (reset_i),
    .killed_i               (killed_i),
    .inst_fault_o           (inst_fault_o),
    .data_fault_o           (data_fault_o),
    .mem_operation_enable_o (mem_operation_enable_o),
    .mem_write_enable_o     (mem_write_enable_o)
);

//--- hw/xosvm_unit.sv
module xosvm_unit (
    input  logic                   clk,
    input  logic                   reset_i,

    // Control register writes
    input  logic                   cfg_write_i,
    input  xosvm_pkg::csr_addr_t   cfg_addr_i,
    input  xosvm_pkg::addr_t       cfg_data_i,
    input  xosvm_pkg::priv_level_e privilege_i,

    // Requests from the pipeline
    input  xosvm_pkg::addr_t       instruction_address_i,
    input  xosvm_pkg::addr_t       mem_address_i,
    input  logic                   mem_read_enable_i,
    input  xosvm_pkg::strobe_t     mem_write_enable_i,
    input  logic                   killed_i,

    // To memory, one cycle later
    output xosvm_pkg::addr_t       instruction_address_o,
    output logic                   inst_fault_o,
    output xosvm_pkg::addr_t       mem_address_o,
    output logic                   data_fault_o,
    output logic                   mem_operation_enable_o,
    output xosvm_pkg::strobe_t     mem_write_enable_o
);

    ////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////

    xosvm_pkg::region_cfg_t [xosvm_pkg::NUM_CHANNELS-1:0] region_cfg;
    xosvm_pkg::addr_t       [xosvm_pkg::NUM_CHANNELS-1:0] channel_address;
    xosvm_pkg::xlate_t      [xosvm_pkg::NUM_CHANNELS-1:0] xlate;
    xosvm_pkg::mem_req_t                                  mem_req;

    // Channel address select
    assign channel_address[xosvm_pkg::INST_CHANNEL] = instruction_address_i;
    assign channel_address[xosvm_pkg::DATA_CHANNEL] = mem_address_i;

    // Request bundle
    assign mem_req.read_enable  = mem_read_enable_i;
    assign mem_req.write_strobe = mem_write_enable_i;
    assign mem_req.killed       = killed_i;

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    vm_config_regs i_vm_config_regs (
        .clk          (clk),
        .reset_i      (reset_i),
        .cfg_write_i  (cfg_write_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_data_i   (cfg_data_i),
        .privilege_i  (privilege_i),
        .region_cfg_o (region_cfg)
    );

    // One checker per channel
    for (genvar k = 0; k < xosvm_pkg::NUM_CHANNELS; k++) begin : gen_region_mmu
        region_mmu i_region_mmu (
            .clk          (clk),
            .reset_i      (reset_i),
            .region_cfg_i (region_cfg[k]),
            .address_i    (channel_address[k]),
            .xlate_o      (xlate[k])
        );
    end

    ////////////////////////////////////////////////////////////
    // Memory issue
    ////////////////////////////////////////////////////////////

    mem_request_gate i_mem_request_gate (
        .clk                    (clk),
        .reset_i                (reset_i),
        .mem_req_i              (mem_req),
        .xlate_i                (xlate),
        .instruction_address_o  (instruction_address_o),
        .inst_fault_o           (inst_fault_o),
        .mem_address_o          (mem_address_o),
        .data_fault_o           (data_fault_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o)
    );

endmodule

//--- hw/mem_request_gate.sv
module mem_request_gate (
    input  logic                                            clk,
    input  logic                                            reset_i,
    input  xosvm_pkg::mem_req_t                             mem_req_i,
    input  xosvm_pkg::xlate_t [xosvm_pkg::NUM_CHANNELS-1:0] xlate_i,
    output xosvm_pkg::addr_t                                instruction_address_o,
    output logic                                            inst_fault_o,
    output xosvm_pkg::addr_t                                mem_address_o,
    output logic                                            data_fault_o,
    output logic                                            mem_operation_enable_o,
    output xosvm_pkg::strobe_t                              mem_write_enable_o
);

    // Request delayed to line up with the checker results
    xosvm_pkg::mem_req_t mem_req_q;

    // Request asks for a load or a store
    logic                mem_access;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_req_q <= '0;
        end
        else begin
            mem_req_q <= mem_req_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory controls
    ////////////////////////////////////////////////////////////

    assign mem_access = (mem_req_q.write_strobe != '0) || mem_req_q.read_enable;

    // Killed or faulting accesses never reach memory
    always_comb begin
        if (!mem_req_q.killed && mem_access && !xlate_i[xosvm_pkg::DATA_CHANNEL].fault) begin
            mem_operation_enable_o = 1'b1;
        end
        else begin
            mem_operation_enable_o = 1'b0;
        end
    end

    // Strobe passes as is, the enable does the gating
    assign mem_write_enable_o = mem_req_q.write_strobe;

    ////////////////////////////////////////////////////////////
    // Channel results onto named outputs
    ////////////////////////////////////////////////////////////

    // Fetch side
    assign instruction_address_o = xlate_i[xosvm_pkg::INST_CHANNEL].address;
    assign inst_fault_o          = xlate_i[xosvm_pkg::INST_CHANNEL].fault;

    // Load/store side
    assign mem_address_o         = xlate_i[xosvm_pkg::DATA_CHANNEL].address;
    assign data_fault_o          = xlate_i[xosvm_pkg::DATA_CHANNEL].fault;

endmodule

//--- hw/region_mmu.sv
module region_mmu (
    input  logic                   clk,
    input  logic                   reset_i,
    input  xosvm_pkg::region_cfg_t region_cfg_i,
    input  xosvm_pkg::addr_t       address_i,
    output xosvm_pkg::xlate_t      xlate_o
);

    // Address after the mask
    xosvm_pkg::addr_t  masked_address;

    // Result before the output register
    xosvm_pkg::xlate_t xlate_d;
    xosvm_pkg::xlate_t xlate_q;

    ////////////////////////////////////////////////////////////
    // Mask, relocate, bound check
    ////////////////////////////////////////////////////////////

    assign masked_address = address_i & region_cfg_i.mask;

    always_comb begin
        if (region_cfg_i.enable) begin
            // Wraps modulo 2^32 by width
            xlate_d.address = masked_address + region_cfg_i.offset;
            // Size is an exclusive upper bound
            xlate_d.fault   = (masked_address >= region_cfg_i.size);
        end
        else begin
            // Translation off, physical address as is
            xlate_d.address = address_i;
            xlate_d.fault   = 1'b0;
        end
    end

    // One cycle through the checker
    always_ff @(posedge clk) begin
        if (reset_i) begin
            xlate_q <= '0;
        end
        else begin
            xlate_q <= xlate_d;
        end
    end

    assign xlate_o = xlate_q;

endmodule

//--- hw/vm_config_regs.sv
module vm_config_regs (
    input  logic                                              clk,
    input  logic                                              reset_i,
    input  logic                                              cfg_write_i,
    input  xosvm_pkg::csr_addr_t                              cfg_addr_i,
    input  xosvm_pkg::addr_t                                  cfg_data_i,
    input  xosvm_pkg::priv_level_e                            privilege_i,
    output xosvm_pkg::region_cfg_t [xosvm_pkg::NUM_CHANNELS-1:0] region_cfg_o
);

    ////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////

    // Global translation switch
    logic             mvmctl_q;

    // Data region
    xosvm_pkg::addr_t mvmdo_q;
    xosvm_pkg::addr_t mvmds_q;
    xosvm_pkg::addr_t mvmdm_q;

    // Instruction region
    xosvm_pkg::addr_t mvmio_q;
    xosvm_pkg::addr_t mvmis_q;
    xosvm_pkg::addr_t mvmim_q;

    // Shared by both channels
    logic             xlate_en;

    ////////////////////////////////////////////////////////////
    // Strobed writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mvmctl_q <= 1'b0;
            mvmdo_q  <= '0;
            mvmds_q  <= '0;
            mvmdm_q  <= '0;
            mvmio_q  <= '0;
            mvmis_q  <= '0;
            mvmim_q  <= '0;
        end
        else if (cfg_write_i) begin
            // Decode against the register map, others dropped
            case (cfg_addr_i)
                // Only the enable bit exists here
                xosvm_pkg::MVMCTL_ADDR: mvmctl_q <= cfg_data_i[0];
                xosvm_pkg::MVMDO_ADDR:  mvmdo_q  <= cfg_data_i;
                xosvm_pkg::MVMDS_ADDR:  mvmds_q  <= cfg_data_i;
                xosvm_pkg::MVMDM_ADDR:  mvmdm_q  <= cfg_data_i;
                xosvm_pkg::MVMIO_ADDR:  mvmio_q  <= cfg_data_i;
                xosvm_pkg::MVMIS_ADDR:  mvmis_q  <= cfg_data_i;
                xosvm_pkg::MVMIM_ADDR:  mvmim_q  <= cfg_data_i;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Channel configuration
    ////////////////////////////////////////////////////////////

    // Machine mode always sees physical addresses
    assign xlate_en = mvmctl_q && (privilege_i != xosvm_pkg::PRIV_MACHINE);

    // Instruction channel
    assign region_cfg_o[xosvm_pkg::INST_CHANNEL].enable = xlate_en;
    assign region_cfg_o[xosvm_pkg::INST_CHANNEL].offset = mvmio_q;
    assign region_cfg_o[xosvm_pkg::INST_CHANNEL].size   = mvmis_q;
    assign region_cfg_o[xosvm_pkg::INST_CHANNEL].mask   = mvmim_q;

    // Data channel
    assign region_cfg_o[xosvm_pkg::DATA_CHANNEL].enable = xlate_en;
    assign region_cfg_o[xosvm_pkg::DATA_CHANNEL].offset = mvmdo_q;
    assign region_cfg_o[xosvm_pkg::DATA_CHANNEL].size   = mvmds_q;
    assign region_cfg_o[xosvm_pkg::DATA_CHANNEL].mask   = mvmdm_q;

endmodule

//--- hw/xosvm_pkg.sv
package xosvm_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////

    // Addresses, offsets, sizes, masks and config write data
    typedef logic [31:0] addr_t;

    // Control register address, custom machine range
    typedef logic [11:0] csr_addr_t;

    // One bit per byte lane of a store
    typedef logic [3:0] strobe_t;

    // Privilege encoding as in the core, value 2 reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_level_e;

    ////////////////////////////////////////////////////////////
    // Channels
    ////////////////////////////////////////////////////////////

    // Instruction fetch and data access, fixed by the core
    localparam int NUM_CHANNELS = 2;
    localparam int INST_CHANNEL = 0;
    localparam int DATA_CHANNEL = 1;

    // Control register map
    localparam csr_addr_t MVMCTL_ADDR = 12'h7C0;
    localparam csr_addr_t MVMDO_ADDR  = 12'h7C1;
    localparam csr_addr_t MVMDS_ADDR  = 12'h7C2;
    localparam csr_addr_t MVMDM_ADDR  = 12'h7C3;
    localparam csr_addr_t MVMIO_ADDR  = 12'h7C4;
    localparam csr_addr_t MVMIS_ADDR  = 12'h7C5;
    localparam csr_addr_t MVMIM_ADDR  = 12'h7C6;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Region setup of one channel, 97 bits
    typedef struct packed {
        logic  enable;
        addr_t offset;
        addr_t size;
        addr_t mask;
    } region_cfg_t;

    // Checker result, 33 bits
    typedef struct packed {
        addr_t address;
        logic  fault;
    } xlate_t;

    // Memory request from execute, 6 bits
    typedef struct packed {
        logic    read_enable;
        strobe_t write_strobe;
        logic    killed;
    } mem_req_t;

endpackage
